// File: filelist.f
hw/cpu_pkg.sv
hw/state_control.sv
hw/datapath.sv
hw/register_file.sv
hw/unified_memory.sv
hw/cpu_core.sv
tests/clock_gen.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_tb -Mdir obj_dir -f filelist.f

sim_output=$(./obj_dir/Vcpu_tb)
echo "$sim_output"

if grep -qx "Testbench passed" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int NUM_ROWS   = 14;
    localparam int NUM_DATA   = 1;
    localparam int HALT_WATCH = 16;
    localparam int SLACK      = 50;

    typedef struct packed {
        word_t      instr;
        logic       retires;     // Low for a word that is jumped over
        logic       wb_en;
        reg_idx_t   wb_reg;
        word_t      wb_val;
        addr_t      pc_after;
        logic [7:0] cycles;      // IF1 up to and including the retire cycle
    } row_t;

    logic     clk;
    logic     reset_n;
    logic     load_en;
    addr_t    load_addr;
    word_t    load_data;
    logic     retire;
    addr_t    pc;
    logic     wb_valid;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     halted;

    row_t  rows [NUM_ROWS];
    word_t data_words [NUM_DATA];

    int value_errors   = 0;
    int latency_errors = 0;
    int other_errors   = 0;
    int cycle_count    = 0;
    int timeout_limit  = SLACK;

    clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(8)) u_clock (
        .clk     (clk),
        .reset_n (reset_n)
    );

    cpu_core #(.MEM_WORDS(MEM_WORDS)) dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .retire    (retire),
        .pc        (pc),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    function automatic word_t encode_reg(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {op, rd, rs, rt, 6'd0};
    endfunction

    function automatic word_t encode_imm(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                         logic [7:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic word_t encode_jump(addr_t target);
        return {OP_JAL, 4'd0, target};
    endfunction

    function automatic row_t make_row(word_t instr, logic retires, logic wb_en, reg_idx_t wr,
                                      word_t wv, addr_t pc_after, logic [7:0] cycles);
        return '{instr, retires, wb_en, wr, wv, pc_after, cycles};
    endfunction

    function automatic int run_length();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].retires) begin
                total += int'(rows[i].cycles);
            end
        end
        return total;
    endfunction

    task automatic build_table();
        rows[0]  = make_row(encode_imm(OP_ADDI, 2'd1, 2'd0, 8'hfd),
                            1'b1, 1'b1, 2'd1, 16'hfffd, 8'd1, 8'd8);    // r1 = -3
        rows[1]  = make_row(encode_imm(OP_ADDI, 2'd2, 2'd0, 8'h7f),
                            1'b1, 1'b1, 2'd2, 16'h007f, 8'd2, 8'd8);
        rows[2]  = make_row(encode_reg(OP_ADD, 2'd3, 2'd1, 2'd2),
                            1'b1, 1'b1, 2'd3, 16'h007c, 8'd3, 8'd8);    // Carry out dropped
        rows[3]  = make_row(encode_reg(OP_ADD, 2'd0, 2'd3, 2'd3),
                            1'b1, 1'b1, 2'd0, 16'h00f8, 8'd4, 8'd8);    // Write to r0
        rows[4]  = make_row(encode_reg(OP_ADD, 2'd2, 2'd0, 2'd1),
                            1'b1, 1'b1, 2'd2, 16'hfffd, 8'd5, 8'd8);    // r0 still zero
        rows[5]  = make_row(encode_imm(OP_SW, 2'd3, 2'd1, 8'h33),
                            1'b1, 1'b0, 2'd0, 16'h0000, 8'd6, 8'd11);   // mem[0x30] = r3
        rows[6]  = make_row(encode_imm(OP_LW, 2'd2, 2'd0, 8'h30),
                            1'b1, 1'b1, 2'd2, 16'h007c, 8'd7, 8'd12);
        rows[7]  = make_row(encode_imm(OP_BEQ, 2'd2, 2'd3, 8'h01),
                            1'b1, 1'b0, 2'd0, 16'h0000, 8'd9, 8'd7);    // Taken
        rows[8]  = make_row(encode_imm(OP_ADDI, 2'd1, 2'd1, 8'h01),
                            1'b0, 1'b0, 2'd0, 16'h0000, 8'd0, 8'd0);
        rows[9]  = make_row(encode_imm(OP_BEQ, 2'd1, 2'd2, 8'h04),
                            1'b1, 1'b0, 2'd0, 16'h0000, 8'd10, 8'd7);   // Not taken
        rows[10] = make_row(encode_jump(8'd12),
                            1'b1, 1'b1, 2'd3, 16'h000b, 8'd12, 8'd7);   // Link to r3
        rows[11] = make_row(encode_imm(OP_ADDI, 2'd2, 2'd0, 8'h01),
                            1'b0, 1'b0, 2'd0, 16'h0000, 8'd0, 8'd0);
        rows[12] = make_row(encode_imm(OP_LW, 2'd1, 2'd0, 8'h0e),
                            1'b1, 1'b1, 2'd1, 16'ha5c3, 8'd13, 8'd12);  // Preloaded word
        rows[13] = make_row(encode_reg(OP_HLT, 2'd0, 2'd0, 2'd0),
                            1'b1, 1'b0, 2'd0, 16'h0000, 8'd13, 8'd5);
        data_words[0] = 16'ha5c3;
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_reg(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            value_errors++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            latency_errors++;
        end
    endtask

    // Later words land after reset but long before their fetch
    initial begin : program_load
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_table();
        timeout_limit = run_length() + SLACK;
        for (int i = 0; i < NUM_ROWS + NUM_DATA; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = addr_t'(i);
            if (i < NUM_ROWS) begin
                load_data = rows[i].instr;
            end else begin
                load_data = data_words[i - NUM_ROWS];
            end
        end
        @(negedge clk);
        load_en = 1'b0;
    end

    initial begin : run_checks
        int cycles;
        do begin
            @(negedge clk);
        end while (!reset_n);    // First negedge with reset high falls in IF1

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].retires) begin
                cycles = 1;
                while (!retire) begin
                    check_flag("halted", halted, 1'b0);
                    if (wb_valid) begin
                        $display("Write-back seen without a retire at %0t", $time);
                        other_errors++;
                    end
                    @(negedge clk);
                    cycles++;
                end
                check_count("latency", cycles, int'(rows[i].cycles));
                check_flag("wb_valid", wb_valid, rows[i].wb_en);
                if (rows[i].wb_en) begin
                    check_reg("wb_reg", wb_reg, rows[i].wb_reg);
                    check_word("wb_data", wb_data, rows[i].wb_val);
                end
                @(negedge clk);      // pc moves on the edge that ends the retire state
                check_addr("pc", pc, rows[i].pc_after);
            end
        end

        for (int n = 0; n < HALT_WATCH; n++) begin
            check_flag("halted", halted, 1'b1);
            if (retire) begin
                $display("Retire pulse after halt at %0t", $time);
                other_errors++;
            end
            @(negedge clk);
        end

        $display("Errors: %0d value, %0d latency, %0d other",
                 value_errors, latency_errors, other_errors);
        if (value_errors + latency_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout, the core did not finish within %0d cycles", timeout_limit);
            $display("Errors: %0d value, %0d latency, %0d other",
                     value_errors, latency_errors, other_errors);
            $display("Testbench failed");
            $finish;
        end
    end

endmodule

// File: tests/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions (
    input logic             clk,
    input logic             reset_n,
    input cpu_pkg::state_t  state,
    input logic             read_m,
    input logic             write_m,
    input logic             ir_write,
    input logic             i_or_d,
    input logic             pc_write,
    input logic             reg_write,
    input logic             retire,
    input logic             halted
);
    import cpu_pkg::*;

    // Single memory port, one direction per cycle
    a_read_write_excl: assert property (@(posedge clk) !(read_m && write_m))
        else $error("read_m and write_m high together");

    a_ir_write_fetch: assert property (@(posedge clk)
        ir_write |-> state inside {S_IF1, S_IF2, S_IF3, S_IF4})
        else $error("ir_write high outside fetch in state %0d", state);

    a_retire_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        retire |=> !retire)
        else $error("retire held for more than one cycle");

    // Reset parks the FSM in S_INIT, quiet from the following edge
    a_reset_quiet: assert property (@(posedge clk)
        !reset_n |=> !(read_m || write_m || ir_write || i_or_d ||
                       pc_write || reg_write || retire || halted))
        else $error("control strobe active during reset");

endmodule

bind state_control cpu_assertions u_assertions (
    .clk       (clk),
    .reset_n   (reset_n),
    .state     (state),
    .read_m    (read_m),
    .write_m   (write_m),
    .ir_write  (ir_write),
    .i_or_d    (i_or_d),
    .pc_write  (pc_write),
    .reg_write (reg_write),
    .retire    (retire),
    .halted    (halted)
);

// File: tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released on a falling edge, so the next rising edge sees it high
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n <= 1'b1;
    end

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
    parameter int MEM_WORDS = 256
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              load_en,
    input  cpu_pkg::addr_t    load_addr,
    input  cpu_pkg::word_t    load_data,
    output logic              retire,
    output cpu_pkg::addr_t    pc,
    output logic              wb_valid,
    output cpu_pkg::reg_idx_t wb_reg,
    output cpu_pkg::word_t    wb_data,
    output logic              halted
);
    import cpu_pkg::*;

    logic     read_m;
    logic     write_m;
    logic     ir_write;
    logic     i_or_d;
    logic     pc_write;
    logic     branch_taken;
    opcode_t  opcode;
    addr_t    mem_addr;
    word_t    mem_wdata;
    word_t    mem_rdata;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;

    // wb_valid is the register write strobe, wb_reg the write index
    state_control u_control (
        .clk          (clk),
        .reset_n      (reset_n),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .read_m       (read_m),
        .write_m      (write_m),
        .ir_write     (ir_write),
        .i_or_d       (i_or_d),
        .pc_write     (pc_write),
        .reg_write    (wb_valid),
        .retire       (retire),
        .halted       (halted)
    );

    datapath u_datapath (
        .clk          (clk),
        .reset_n      (reset_n),
        .ir_write     (ir_write),
        .i_or_d       (i_or_d),
        .pc_write     (pc_write),
        .reg_write    (wb_valid),
        .mem_rdata    (mem_rdata),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .opcode       (opcode),
        .branch_taken (branch_taken),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .rd_idx       (wb_reg),
        .wb_data      (wb_data),
        .pc           (pc)
    );

    register_file u_regs (
        .clk      (clk),
        .reset_n  (reset_n),
        .rs_idx   (rs_idx),
        .rt_idx   (rt_idx),
        .rd_idx   (wb_reg),
        .write_en (wb_valid),
        .wdata    (wb_data),
        .rs_data  (rs_data),
        .rt_data  (rt_data)
    );

    unified_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk       (clk),
        .read_m    (read_m),
        .write_m   (write_m),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: hw/unified_memory.sv
`timescale 1ns/1ps

module unified_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           read_m,
    input  logic           write_m,
    input  cpu_pkg::addr_t addr,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata,
    input  logic           load_en,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::word_t load_data
);
    import cpu_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t mem [MEM_WORDS];

    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] load_idx;

    // Addresses wrap on a smaller array
    assign idx      = addr[IDX_W-1:0];
    assign load_idx = load_addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;   // Program load wins over the core
        end else if (write_m) begin
            mem[idx] <= wdata;
        end
    end

    // One cycle read latency, word held while read_m is low
    always_ff @(posedge clk) begin
        if (read_m) begin
            rdata <= mem[idx];
        end
    end

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic              clk,
    input  logic              reset_n,
    input  cpu_pkg::reg_idx_t rs_idx,
    input  cpu_pkg::reg_idx_t rt_idx,
    input  cpu_pkg::reg_idx_t rd_idx,
    input  logic              write_en,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rs_data,
    output cpu_pkg::word_t    rt_data
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 4;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && rd_idx != 2'd0) begin
            regs[rd_idx] <= wdata;
        end
    end

    // r0 is hardwired zero
    assign rs_data = (rs_idx == 2'd0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == 2'd0) ? '0 : regs[rt_idx];

endmodule

// File: hw/datapath.sv
`timescale 1ns/1ps

module datapath (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              ir_write,
    input  logic              i_or_d,
    input  logic              pc_write,
    input  logic              reg_write,
    input  cpu_pkg::word_t    mem_rdata,
    input  cpu_pkg::word_t    rs_data,
    input  cpu_pkg::word_t    rt_data,
    output cpu_pkg::opcode_t  opcode,
    output logic              branch_taken,
    output cpu_pkg::addr_t    mem_addr,
    output cpu_pkg::word_t    mem_wdata,
    output cpu_pkg::reg_idx_t rs_idx,
    output cpu_pkg::reg_idx_t rt_idx,
    output cpu_pkg::reg_idx_t rd_idx,
    output cpu_pkg::word_t    wb_data,
    output cpu_pkg::addr_t    pc
);
    import cpu_pkg::*;

    word_t ir;
    word_t mdr;
    word_t alu_out;
    word_t instr;
    word_t imm_ext;
    word_t alu_b;
    word_t alu_result;
    addr_t pc_plus1;
    addr_t branch_target;
    addr_t jal_target;
    addr_t next_pc;

    // Fetched word is decoded straight from memory while the IR is loading,
    // so IF4 already sees the opcode
    assign instr  = ir_write ? mem_rdata : ir;
    assign opcode = opcode_t'(instr[OP_MSB:OP_LSB]);

    assign imm_ext = {{8{ir[IMM_MSB]}}, ir[IMM_MSB:IMM_LSB]};

    // Second read port carries rd for SW data and the BEQ compare
    assign rs_idx = ir[RS_MSB:RS_LSB];
    assign rt_idx = (opcode == OP_ADD) ? ir[RT_MSB:RT_LSB] : ir[RD_MSB:RD_LSB];
    assign rd_idx = (opcode == OP_JAL) ? LINK_REG : ir[RD_MSB:RD_LSB];

    assign alu_b      = (opcode == OP_ADD) ? rt_data : imm_ext;
    assign alu_result = rs_data + alu_b;

    assign branch_taken = (opcode == OP_BEQ) && (rs_data == rt_data);

    assign pc_plus1      = pc + 8'd1;
    assign branch_target = pc_plus1 + imm_ext[$bits(addr_t)-1:0];
    assign jal_target    = ir[TGT_LSB +: $bits(addr_t)];

    always_comb begin
        case (opcode)
            OP_JAL:  next_pc = jal_target;
            OP_BEQ:  next_pc = branch_taken ? branch_target : pc_plus1;
            default: next_pc = pc_plus1;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_LW:   wb_data = mdr;
            OP_JAL:  wb_data = {8'd0, pc_plus1};   // Link address
            default: wb_data = alu_out;
        endcase
    end

    assign mem_addr  = i_or_d ? alu_out[$bits(addr_t)-1:0] : pc;
    assign mem_wdata = rt_data;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
        end else if (pc_write) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ir_write) begin
            ir <= mem_rdata;
        end
        if (i_or_d) begin
            mdr <= mem_rdata;   // Last capture in MEM4 wins
        end
        // ALU result frozen once memory access or write-back starts
        if (!ir_write && !i_or_d && !reg_write) begin
            alu_out <= alu_result;
        end
    end

endmodule

// File: hw/state_control.sv
`timescale 1ns/1ps

module state_control (
    input  logic             clk,
    input  logic             reset_n,
    input  cpu_pkg::opcode_t opcode,
    input  logic             branch_taken,
    output logic             read_m,
    output logic             write_m,
    output logic             ir_write,
    output logic             i_or_d,
    output logic             pc_write,
    output logic             reg_write,
    output logic             retire,
    output logic             halted
);
    import cpu_pkg::*;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= S_INIT;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        read_m     = 1'b0;
        write_m    = 1'b0;
        ir_write   = 1'b0;
        i_or_d     = 1'b0;
        pc_write   = 1'b0;
        reg_write  = 1'b0;
        retire     = 1'b0;
        halted     = 1'b0;
        next_state = state;

        case (state)
            S_INIT: next_state = S_IF1;

            // Fetch word at pc, valid from IF2, IR loads at the end of IF4
            S_IF1, S_IF2, S_IF3: begin
                read_m     = 1'b1;
                ir_write   = 1'b1;
                next_state = state_t'(state + 4'd1);
            end
            S_IF4: begin
                read_m   = 1'b1;
                ir_write = 1'b1;
                if (opcode == OP_JAL) begin   // No operands to decode
                    next_state = S_EX1;
                end else begin
                    next_state = S_ID;
                end
            end

            S_ID: begin
                if (opcode == OP_HLT) begin
                    retire     = 1'b1;        // pc stays on the HLT word
                    next_state = S_HALT;
                end else begin
                    next_state = S_EX1;
                end
            end

            S_EX1: next_state = S_EX2;

            S_EX2: begin
                // Both outcomes of BEQ end here, the datapath picks the target
                if (branch_taken || opcode == OP_BEQ) begin
                    pc_write   = 1'b1;
                    retire     = 1'b1;
                    next_state = S_IF1;
                end else if (opcode == OP_LW || opcode == OP_SW) begin
                    next_state = S_MEM1;
                end else begin
                    next_state = S_WB;
                end
            end

            // Address and strobes held flat over the whole access
            S_MEM1, S_MEM2, S_MEM3: begin
                i_or_d     = 1'b1;
                read_m     = (opcode == OP_LW);
                write_m    = (opcode == OP_SW);
                next_state = state_t'(state + 4'd1);
            end
            S_MEM4: begin
                i_or_d  = 1'b1;
                read_m  = (opcode == OP_LW);
                write_m = (opcode == OP_SW);
                if (opcode == OP_LW) begin
                    next_state = S_WB;
                end else begin
                    pc_write   = 1'b1;
                    retire     = 1'b1;
                    next_state = S_IF1;
                end
            end

            S_WB: begin
                reg_write  = 1'b1;
                pc_write   = 1'b1;
                retire     = 1'b1;
                next_state = S_IF1;
            end

            S_HALT: halted = 1'b1;

            default: next_state = S_INIT;
        endcase
    end

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  addr_t;     // Word address
    typedef logic [1:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_ADDI = 4'h1,
        OP_LW   = 4'h2,
        OP_SW   = 4'h3,
        OP_BEQ  = 4'h4,
        OP_JAL  = 4'h5,
        OP_HLT  = 4'hf
    } opcode_t;

    typedef enum logic [3:0] {
        S_IF1  = 4'b0000,
        S_IF2  = 4'b0001,
        S_IF3  = 4'b0010,
        S_IF4  = 4'b0011,
        S_ID   = 4'b0100,
        S_EX1  = 4'b0101,
        S_EX2  = 4'b0110,
        S_MEM1 = 4'b0111,
        S_MEM2 = 4'b1000,
        S_MEM3 = 4'b1001,
        S_MEM4 = 4'b1010,
        S_WB   = 4'b1011,
        S_HALT = 4'b1100,
        S_INIT = 4'b1111
    } state_t;

    // Instruction fields
    localparam int OP_MSB  = 15;
    localparam int OP_LSB  = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 10;
    localparam int RS_MSB  = 9;
    localparam int RS_LSB  = 8;
    localparam int RT_MSB  = 7;
    localparam int RT_LSB  = 6;
    localparam int IMM_MSB = 7;      // Signed, shares bits with rt
    localparam int IMM_LSB = 0;
    localparam int TGT_LSB = 0;      // JAL target in 11:0, low address bits used

    localparam reg_idx_t LINK_REG = 2'd3;

endpackage
